// ==== Makefile ====
# Verilator flow for the MNIST pooling project

VERILATOR  ?= verilator
FILE_LIST  ?= compile.f
TB_TOP     ?= tb_mnist_pool
RTL_TOP    ?= mnist_pool_top
OBJ_DIR    ?= obj_dir
LINT_FLAGS ?= -Wall
SIM_FLAGS  ?= --binary --timing -j 0
PASS_MSG   ?= *** PASSED ***

SIM_BIN := $(OBJ_DIR)/V$(TB_TOP)
SOURCES := $(shell grep -v '^+' $(FILE_LIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) --timing -f $(FILE_LIST) --top-module $(RTL_TOP)

$(SIM_BIN): $(FILE_LIST) $(SOURCES)
	$(VERILATOR) $(SIM_FLAGS) -f $(FILE_LIST) --top-module $(TB_TOP) --Mdir $(OBJ_DIR)

sim: $(SIM_BIN)
	@out="$$(./$(SIM_BIN) 2>&1)"; echo "$$out"; echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

// ==== common/img_pkg.sv ====
`default_nettype none

package img_pkg;

    localparam int IMG_W       = 28;
    localparam int IMG_H       = 28;
    localparam int TOTAL_BYTES = IMG_W * IMG_H;   // 784
    localparam int POOL_W      = IMG_W / 2;
    localparam int POOL_TOTAL  = (IMG_W / 2) * (IMG_H / 2);   // 196

    localparam int PIX_W  = 8;
    localparam int ADDR_W = 10;
    localparam int SUM_W  = 16;   // 196 * 255 = 49980 fits

    typedef logic [PIX_W-1:0] pixel_t;

    // synthetic test image, wraps at 8 bits
    function automatic pixel_t pattern_pixel(input int row, input int col);
        int val;
        val = row * 9 + col * 7 + row * col;
        return pixel_t'(val);
    endfunction

endpackage

`default_nettype wire

// ==== common/pace_pkg.sv ====
`default_nettype none

package pace_pkg;

    // 12 clocks per pixel
    localparam int CLK_INTERVAL = 11;
    localparam int VLD_PHASE    = 2;   // rom output sampled here
    localparam int CNT_W        = 4;

    // row/column position in the full image
    localparam int POS_W  = 5;
    // pooled pixel count per frame
    localparam int PCNT_W = 8;

endpackage

`default_nettype wire

// ==== compile.f ====
common/img_pkg.sv
common/pace_pkg.sv
img_src/img_rom.sv
img_src/img_stream.sv
rtl/max_pool_2x2.sv
rtl/pool_collect.sv
rtl/mnist_pool_top.sv
tests/tb_mnist_pool.sv

// ==== img_src/img_rom.sv ====
`default_nettype none

module img_rom
    import img_pkg::*;
(
    input  logic              clk,
    input  logic [ADDR_W-1:0] addr,
    output pixel_t            dout
);

    pixel_t mem [TOTAL_BYTES];

    // row-major fill
    initial begin
        for (int r = 0; r < IMG_H; r++) begin
            for (int c = 0; c < IMG_W; c++) begin
                mem[r * IMG_W + c] = pattern_pixel(r, c);
            end
        end
    end

    always_ff @(posedge clk) begin
        dout <= mem[addr];   // one cycle latency
    end

endmodule

`default_nettype wire

// ==== img_src/img_stream.sv ====
`default_nettype none

module img_stream
    import img_pkg::*;
    import pace_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    input  logic   start,
    output pixel_t img_dout,
    output logic   dout_vld
);

    logic              working;
    logic [CNT_W-1:0]  cnt;
    logic [ADDR_W-1:0] rom_addr;
    pixel_t            rom_dout;

    logic addr_end;
    logic sample;

    img_rom u_rom (
        .clk  (clk),
        .addr (rom_addr),
        .dout (rom_dout)
    );

    assign addr_end = (rom_addr == ADDR_W'(TOTAL_BYTES));
    assign sample   = working && (cnt == CNT_W'(VLD_PHASE));

    // a second start keeps us running, address untouched
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            working <= 1'b0;
        end else if (start) begin
            working <= 1'b1;
        end else if (addr_end) begin
            working <= 1'b0;
        end
    end

    // pacing counter
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt <= '0;
        end else if (working && cnt < CNT_W'(CLK_INTERVAL)) begin
            cnt <= cnt + 1'b1;
        end else begin
            cnt <= '0;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rom_addr <= '0;
        end else if (addr_end) begin
            rom_addr <= '0;   // frame finished
        end else if (working && cnt == CNT_W'(CLK_INTERVAL)) begin
            rom_addr <= rom_addr + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dout_vld <= 1'b0;
        end else begin
            dout_vld <= sample;
        end
    end

    always_ff @(posedge clk) begin
        if (sample) begin
            img_dout <= rom_dout;   // rom has settled by this phase
        end
    end

endmodule

`default_nettype wire

// ==== rtl/max_pool_2x2.sv ====
`default_nettype none

module max_pool_2x2
    import img_pkg::*;
    import pace_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    input  pixel_t pix,
    input  logic   pix_vld,
    output pixel_t pool_pix,
    output logic   pool_vld
);

    logic [POS_W-1:0] col;
    logic [POS_W-1:0] row;
    logic [POS_W-2:0] slot;

    pixel_t left_pix;
    pixel_t pair_max;
    pixel_t line_buf [POOL_W];

    logic pair_end;
    logic out_hit;

    assign slot     = col[POS_W-1:1];   // pooled column
    assign pair_end = pix_vld && col[0];
    assign out_hit  = pair_end && row[0];
    assign pair_max = (pix > left_pix) ? pix : left_pix;

    // position of the incoming pixel
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            col <= '0;
            row <= '0;
        end else if (pix_vld) begin
            if (col == POS_W'(IMG_W - 1)) begin
                col <= '0;
                if (row == POS_W'(IMG_H - 1)) begin
                    row <= '0;
                end else begin
                    row <= row + 1'b1;
                end
            end else begin
                col <= col + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pix_vld && !col[0]) begin
            left_pix <= pix;   // first of the pair
        end
    end

    // even rows fill the half-line buffer
    always_ff @(posedge clk) begin
        if (pair_end && !row[0]) begin
            line_buf[slot] <= pair_max;
        end
    end

    // odd rows close the 2x2 window
    always_ff @(posedge clk) begin
        if (out_hit) begin
            pool_pix <= (pair_max > line_buf[slot]) ? pair_max : line_buf[slot];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pool_vld <= 1'b0;
        end else begin
            pool_vld <= out_hit;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/mnist_pool_top.sv ====
`default_nettype none

module mnist_pool_top
    import img_pkg::*;
(
    input  logic             clk,
    input  logic             rst_n,
    input  logic             start,
    output pixel_t           pool_pix,
    output logic             pool_vld,
    output logic             frame_done,
    output logic [SUM_W-1:0] frame_sum
);

    pixel_t img_dout;
    logic   dout_vld;

    // one pixel every 12 clocks
    img_stream u_stream (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (start),
        .img_dout (img_dout),
        .dout_vld (dout_vld)
    );

    max_pool_2x2 u_pool (
        .clk      (clk),
        .rst_n    (rst_n),
        .pix      (img_dout),
        .pix_vld  (dout_vld),
        .pool_pix (pool_pix),
        .pool_vld (pool_vld)
    );

    pool_collect u_collect (
        .clk        (clk),
        .rst_n      (rst_n),
        .pool_pix   (pool_pix),
        .pool_vld   (pool_vld),
        .frame_done (frame_done),
        .frame_sum  (frame_sum)
    );

endmodule

`default_nettype wire

// ==== rtl/pool_collect.sv ====
`default_nettype none

module pool_collect
    import img_pkg::*;
    import pace_pkg::*;
(
    input  logic             clk,
    input  logic             rst_n,
    input  pixel_t           pool_pix,
    input  logic             pool_vld,
    output logic             frame_done,
    output logic [SUM_W-1:0] frame_sum
);

    logic [PCNT_W-1:0] pix_cnt;
    logic [SUM_W-1:0]  acc;
    logic [SUM_W-1:0]  acc_next;
    logic              last_pix;

    assign acc_next = acc + SUM_W'(pool_pix);
    assign last_pix = pool_vld && (pix_cnt == PCNT_W'(POOL_TOTAL - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pix_cnt <= '0;
            acc     <= '0;
        end else if (last_pix) begin
            pix_cnt <= '0;   // ready for the next frame
            acc     <= '0;
        end else if (pool_vld) begin
            pix_cnt <= pix_cnt + 1'b1;
            acc     <= acc_next;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            frame_done <= 1'b0;
        end else begin
            frame_done <= last_pix;
        end
    end

    // held until the next frame ends
    always_ff @(posedge clk) begin
        if (last_pix) begin
            frame_sum <= acc_next;
        end
    end

endmodule

`default_nettype wire

// ==== tests/tb_mnist_pool.sv ====
`default_nettype none

module tb_mnist_pool
    import img_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD    = 20;
    localparam int RST_CYCLES    = 8;
    localparam int QUIET_CYCLES  = 100;
    localparam int SETTLE_CYCLES = 40;      // stream winds down after frame_done
    localparam int FRAME_TIMEOUT = 12000;   // a frame takes about 9400 cycles
    localparam int ROW_GAP       = 24;
    localparam int N_RUNS        = 4;

    typedef struct {
        int    idle;
        bit    rand_gap;
        bit    mid_start;
        string label;
    } run_t;

    logic             clk;
    logic             rst_n;
    logic             start;
    pixel_t           pool_pix;
    logic             pool_vld;
    logic             frame_done;
    logic [SUM_W-1:0] frame_sum;

    run_t   runs [N_RUNS];
    pixel_t exp_pool [POOL_TOTAL];
    int     exp_sum;

    mnist_pool_top dut0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .pool_pix   (pool_pix),
        .pool_vld   (pool_vld),
        .frame_done (frame_done),
        .frame_sum  (frame_sum)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // source image, low eight bits of the pattern rule
    function automatic int src_pixel(input int r, input int c);
        return (r * 9 + c * 7 + r * c) % 256;
    endfunction

    task automatic build_model();
        int m;
        int v;
        exp_sum = 0;
        for (int pr = 0; pr < IMG_H / 2; pr++) begin
            for (int pc = 0; pc < POOL_W; pc++) begin
                m = 0;
                for (int dr = 0; dr < 2; dr++) begin
                    for (int dc = 0; dc < 2; dc++) begin
                        v = src_pixel(2 * pr + dr, 2 * pc + dc);
                        if (v > m) m = v;
                    end
                end
                exp_pool[pr * POOL_W + pc] = pixel_t'(m);
                exp_sum += m;
            end
        end
    endtask

    task automatic fail_stop(input string msg);
        $display("%s", msg);
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_val(input logic [31:0] got, input logic [31:0] exp,
                             input string msg);
        if (got !== exp) begin
            fail_stop($sformatf("Error at %0t ns: %s, got %0d, expected %0d",
                                $time, msg, got, exp));
        end
    endtask

    // outputs must stay silent
    task automatic quiet_check(input int n, input string msg);
        repeat (n) begin
            @(negedge clk);
            check_val(pool_vld, 1'b0, {msg, ": unexpected pool_vld"});
            check_val(frame_done, 1'b0, {msg, ": unexpected frame_done"});
        end
    endtask

    task automatic pulse_start();
        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
    endtask

    task automatic run_frame(input run_t r);
        int gap;
        int cyc;
        int n_vld;
        int last_vld;
        bit done;
        bit mid_sent;
        bit mid_now;
        gap = r.idle;
        if (r.rand_gap) gap += $urandom % 8;
        repeat (gap) @(posedge clk);
        pulse_start();
        cyc      = 0;
        n_vld    = 0;
        last_vld = 0;
        done     = 1'b0;
        mid_sent = 1'b0;
        while (!done && cyc < FRAME_TIMEOUT) begin
            @(posedge clk);
            mid_now = r.mid_start && !mid_sent && (n_vld == POOL_TOTAL / 2);
            start <= mid_now;   // extra start halfway through
            if (mid_now) mid_sent = 1'b1;
            @(negedge clk);
            cyc++;
            if (pool_vld) begin
                check_val(n_vld < POOL_TOTAL, 1'b1, {r.label, ": more than 196 strobes"});
                check_val(pool_pix, exp_pool[n_vld],
                          $sformatf("%s: pooled pixel %0d", r.label, n_vld));
                if (n_vld % POOL_W != 0) begin
                    check_val(cyc - last_vld, ROW_GAP,
                              $sformatf("%s: strobe gap before pixel %0d", r.label, n_vld));
                end
                last_vld = cyc;
                n_vld++;
            end
            if (frame_done) begin
                check_val(cyc - last_vld, 1, {r.label, ": frame_done delay"});
                check_val(n_vld, POOL_TOTAL, {r.label, ": strobes per frame"});
                check_val(frame_sum, exp_sum, {r.label, ": frame_sum"});
                done = 1'b1;
            end
        end
        if (!done) begin
            fail_stop({"timeout: frame_done never came in run '", r.label, "'"});
        end
        $display("%s: %0d pooled pixels, sum %0d", r.label, n_vld, frame_sum);
    endtask

    initial begin
        void'($urandom(32'hb795_a253));
        rst_n = 1'b0;
        start = 1'b0;
        runs[0] = '{0, 1'b0, 1'b0, "first frame"};
        runs[1] = '{3, 1'b1, 1'b0, "random gap"};
        runs[2] = '{0, 1'b0, 1'b1, "mid-frame start"};
        runs[3] = '{11, 1'b1, 1'b1, "random gap and mid-frame start"};
        build_model();
        repeat (RST_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        quiet_check(QUIET_CYCLES, "idle after reset");
        for (int i = 0; i < N_RUNS; i++) begin
            run_frame(runs[i]);
            quiet_check(SETTLE_CYCLES, {runs[i].label, " tail"});
        end
        $display("*** PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire
